/* rv_pkg.sv */
package rv_pkg;

    // Datapath and memory widths
    localparam int xlen   = 32;
    localparam int mem_aw = 10;
    localparam int rf_aw  = 5;
    localparam int host_aw = 16;

    // Host byte address map with 4 KB per memory
    localparam logic [host_aw-1:0] host_imem_base = 16'h0000;
    localparam logic [host_aw-1:0] host_dmem_base = 16'h1000;
    localparam logic [host_aw-1:0] host_ctrl_addr = 16'h2000;

    localparam logic [xlen-1:0] reset_pc = '0;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_MEM = 2'd0,
        WB_ALU = 2'd1,
        WB_PC4 = 2'd2
    } wb_sel_e;

    // Decoded controls
    typedef struct packed {
        logic    reg_write;
        logic    a_sel_pc;
        logic    b_sel_imm;
        alu_op_e alu_op;
        logic    mem_read;
        logic    mem_write;
        logic    branch;
        logic    jal;
        logic    jalr;
        logic    ecall;
        wb_sel_e wb_sel;
    } ctrl_t;

endpackage

/* mem_port_if.sv */
`timescale 1ns/1ns

interface mem_port_if import rv_pkg::*; ();
    logic              en;
    logic              we;
    logic [mem_aw-1:0] addr;
    logic [xlen-1:0]   wdata;
    logic [xlen-1:0]   rdata;

    modport requester (output en, we, addr, wdata, input rdata);
    modport memory (input en, we, addr, wdata, output rdata);
endinterface

/* rv_regfile.sv */
`timescale 1ns/1ns

module rv_regfile import rv_pkg::*; (
    input  logic             clk,
    input  logic             arst_n,
    input  logic [rf_aw-1:0] ra1,
    input  logic [rf_aw-1:0] ra2,
    input  logic [rf_aw-1:0] wa,
    input  logic [xlen-1:0]  wd,
    input  logic             we,
    output logic [xlen-1:0]  rd1,
    output logic [xlen-1:0]  rd2
);
    logic [xlen-1:0] regs [0:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // x0 reads zero, same-cycle write is bypassed
    assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

/* rv_decode.sv */
`timescale 1ns/1ns

module rv_decode import rv_pkg::*; (
    input  logic [xlen-1:0] instr,
    output ctrl_t           ctrl,
    output logic [xlen-1:0] imm,
    output logic            illegal
);
    logic [2:0] funct3;
    logic       f7_alt;
    alu_op_e    arith_op;

    assign funct3 = instr[14:12];
    assign f7_alt = instr[30];

    // Shared funct3 map for register and immediate ALU ops
    always_comb begin
        case (funct3)
            3'b001:  arith_op = ALU_SLL;
            3'b010:  arith_op = ALU_SLT;
            3'b011:  arith_op = ALU_SLTU;
            3'b100:  arith_op = ALU_XOR;
            3'b101:  arith_op = f7_alt ? ALU_SRA : ALU_SRL;
            3'b110:  arith_op = ALU_OR;
            3'b111:  arith_op = ALU_AND;
            default: arith_op = ALU_ADD;
        endcase
    end

    always_comb begin
        ctrl    = '{alu_op: ALU_ADD, wb_sel: WB_ALU, default: 1'b0};
        imm     = '0;
        illegal = 1'b0;
        case (opcode_e'(instr[6:0]))
            OP_LUI, OP_AUIPC: begin
                ctrl.reg_write = 1'b1;
                ctrl.b_sel_imm = 1'b1;
                ctrl.a_sel_pc  = (instr[6:0] == OP_AUIPC);
                imm            = {instr[31:12], 12'b0};
            end
            OP_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.jal       = 1'b1;
                ctrl.wb_sel    = WB_PC4;
                imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            OP_JALR: begin
                ctrl.reg_write = 1'b1;
                ctrl.b_sel_imm = 1'b1;
                ctrl.jalr      = 1'b1;
                ctrl.wb_sel    = WB_PC4;
                imm            = {{20{instr[31]}}, instr[31:20]};
                illegal        = (funct3 != 3'b000);
            end
            OP_BRANCH: begin
                ctrl.branch = 1'b1;
                imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
                illegal     = (funct3[2:1] == 2'b01);
            end
            OP_LOAD: begin
                ctrl.reg_write = 1'b1;
                ctrl.b_sel_imm = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.wb_sel    = WB_MEM;
                imm            = {{20{instr[31]}}, instr[31:20]};
                illegal        = (funct3 != 3'b010);
            end
            OP_STORE: begin
                ctrl.b_sel_imm = 1'b1;
                ctrl.mem_write = 1'b1;
                imm            = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                illegal        = (funct3 != 3'b010);
            end
            OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.b_sel_imm = 1'b1;
                ctrl.alu_op    = arith_op;
                imm            = {{20{instr[31]}}, instr[31:20]};
            end
            OP_REG: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = (funct3 == 3'b000 && f7_alt) ? ALU_SUB : arith_op;
            end
            OP_SYSTEM: begin
                ctrl.ecall = (instr == 32'h0000_0073);
                illegal    = !ctrl.ecall;
            end
            default: illegal = 1'b1;
        endcase
        // Unknown encodings leave the NOP controls in place
        if (illegal) begin
            ctrl = '{alu_op: ALU_ADD, wb_sel: WB_ALU, default: 1'b0};
        end
    end

endmodule

/* rv_execute.sv */
`timescale 1ns/1ns

module rv_execute import rv_pkg::*; (
    input  ctrl_t           ctrl,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] rs1,
    input  logic [xlen-1:0] rs2,
    input  logic [xlen-1:0] imm,
    input  logic [2:0]      funct3,
    output logic [xlen-1:0] alu_res,
    output logic            redirect,
    output logic [xlen-1:0] target
);
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic            br_eq;
    logic            br_lt;
    logic            taken;

    assign a = ctrl.a_sel_pc ? pc : rs1;
    assign b = ctrl.b_sel_imm ? imm : rs2;

    always_comb begin
        case (ctrl.alu_op)
            ALU_SUB:  alu_res = a - b;
            ALU_SLL:  alu_res = a << b[4:0];
            ALU_SLT:  alu_res = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: alu_res = {31'b0, a < b};
            ALU_XOR:  alu_res = a ^ b;
            ALU_SRL:  alu_res = a >> b[4:0];
            ALU_SRA:  alu_res = $signed(a) >>> b[4:0];
            ALU_OR:   alu_res = a | b;
            ALU_AND:  alu_res = a & b;
            default:  alu_res = a + b;
        endcase
    end

    // Branch comparator, funct3[1] picks unsigned compare
    assign br_eq = (rs1 == rs2);
    assign br_lt = funct3[1] ? (rs1 < rs2) : ($signed(rs1) < $signed(rs2));
    assign taken = funct3[2] ? (br_lt ^ funct3[0]) : (br_eq ^ funct3[0]);

    assign redirect = (ctrl.branch && taken) || ctrl.jalr;
    assign target   = ctrl.jalr ? {alu_res[xlen-1:1], 1'b0} : pc + imm;

endmodule

/* rv_core.sv */
`timescale 1ns/1ns

module rv_core import rv_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        run,
    input  logic        start,
    output logic        halt,
    mem_port_if.requester fetch,
    mem_port_if.requester data
);
    logic [xlen-1:0]  pc_f, pc_d, pc_x, pc_wb;
    logic             valid_d, valid_x, valid_wb;
    logic [xlen-1:0]  instr_d;
    ctrl_t            ctrl_d, ctrl_x, ctrl_wb;
    logic [xlen-1:0]  imm_d, imm_x;
    logic             illegal_d, illegal_x;
    logic [rf_aw-1:0] ra1, ra2, rd_x, rd_wb;
    logic [xlen-1:0]  rd1, rd2, rs1_d, rs2_d, rs1_x, rs2_x;
    logic [2:0]       funct3_x;
    logic [xlen-1:0]  alu_res_x, target_x, alu_wb, wd, fwd_x_val;
    logic             x_hit1, x_hit2;
    logic             redirect_x, ecall_x, kill_x, stall, jal_d, rf_we;

    //////////////////////////////////////////////////////////////////////
    // Fetch and decode
    //////////////////////////////////////////////////////////////////////

    // Stall refetches the decode word so it is held for a cycle
    assign fetch.en    = run && !start;
    assign fetch.we    = 1'b0;
    assign fetch.wdata = '0;
    assign fetch.addr  = stall ? pc_d[mem_aw+1:2] : pc_f[mem_aw+1:2];
    assign instr_d     = fetch.rdata;

    rv_decode decode_i (
        .instr   (instr_d),
        .ctrl    (ctrl_d),
        .imm     (imm_d),
        .illegal (illegal_d)
    );

    // LUI carries immediate bits in the rs1 field
    assign ra1 = (instr_d[6:0] == OP_LUI) ? '0 : instr_d[19:15];
    assign ra2 = instr_d[24:20];

    rv_regfile regfile_i (
        .clk    (clk),
        .arst_n (arst_n),
        .ra1    (ra1),
        .ra2    (ra2),
        .wa     (rd_wb),
        .wd     (wd),
        .we     (rf_we),
        .rd1    (rd1),
        .rd2    (rd2)
    );

    // Writeback results arrive through the register file bypass
    assign fwd_x_val = (ctrl_x.wb_sel == WB_PC4) ? pc_x + 32'd4 : alu_res_x;
    assign x_hit1    = valid_x && ctrl_x.reg_write && rd_x == ra1 && ra1 != '0;
    assign x_hit2    = valid_x && ctrl_x.reg_write && rd_x == ra2 && ra2 != '0;
    assign rs1_d     = x_hit1 ? fwd_x_val : rd1;
    assign rs2_d     = x_hit2 ? fwd_x_val : rd2;

    // Load-use hazard
    assign stall = valid_x && ctrl_x.mem_read && valid_d && rd_x != '0
                   && (rd_x == ra1 || rd_x == ra2);
    assign jal_d = valid_d && ctrl_d.jal && !stall;

    //////////////////////////////////////////////////////////////////////
    // Execute
    //////////////////////////////////////////////////////////////////////

    rv_execute execute_i (
        .ctrl     (ctrl_x),
        .pc       (pc_x),
        .rs1      (rs1_x),
        .rs2      (rs2_x),
        .imm      (imm_x),
        .funct3   (funct3_x),
        .alu_res  (alu_res_x),
        .redirect (redirect_x),
        .target   (target_x)
    );

    assign ecall_x = ctrl_x.ecall || illegal_x;
    assign kill_x  = valid_x && (redirect_x || ecall_x);
    assign halt    = run && valid_x && ecall_x;

    assign data.en    = run && valid_x && (ctrl_x.mem_read || ctrl_x.mem_write);
    assign data.we    = ctrl_x.mem_write;
    assign data.addr  = alu_res_x[mem_aw+1:2];
    assign data.wdata = rs2_x;

    //////////////////////////////////////////////////////////////////////
    // Writeback
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (ctrl_wb.wb_sel)
            WB_MEM:  wd = data.rdata;
            WB_PC4:  wd = pc_wb + 32'd4;
            default: wd = alu_wb;
        endcase
    end
    assign rf_we = valid_wb && ctrl_wb.reg_write;

    // Stage valids and PC
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc_f     <= reset_pc;
            valid_d  <= 1'b0;
            valid_x  <= 1'b0;
            valid_wb <= 1'b0;
        end else if (start || !run) begin
            pc_f     <= reset_pc;
            valid_d  <= 1'b0;
            valid_x  <= 1'b0;
            valid_wb <= 1'b0;
        end else begin
            valid_wb <= valid_x;
            if (kill_x) begin
                pc_f    <= redirect_x ? target_x : pc_f;
                valid_d <= 1'b0;
                valid_x <= 1'b0;
            end else if (stall) begin
                valid_x <= 1'b0;
            end else if (jal_d) begin
                pc_f    <= pc_d + imm_d;
                valid_d <= 1'b0;
                valid_x <= 1'b1;
            end else begin
                pc_f    <= pc_f + 32'd4;
                valid_d <= 1'b1;
                valid_x <= valid_d;
            end
        end
    end

    // Pipeline payload
    always_ff @(posedge clk) begin
        if (!stall) begin
            pc_d <= pc_f;
        end
        pc_x      <= pc_d;
        ctrl_x    <= ctrl_d;
        imm_x     <= imm_d;
        illegal_x <= illegal_d;
        rs1_x     <= rs1_d;
        rs2_x     <= rs2_d;
        rd_x      <= instr_d[11:7];
        funct3_x  <= instr_d[14:12];
        pc_wb     <= pc_x;
        ctrl_wb   <= ctrl_x;
        rd_wb     <= rd_x;
        alu_wb    <= alu_res_x;
    end

endmodule

/* rv_mem.sv */
`timescale 1ns/1ns

module rv_mem import rv_pkg::*; (
    input  logic      clk,
    mem_port_if.memory imem,
    mem_port_if.memory dmem
);
    logic [xlen-1:0] imem_arr [0:(1<<mem_aw)-1];
    logic [xlen-1:0] dmem_arr [0:(1<<mem_aw)-1];

    // Instruction memory, written only by the host
    always_ff @(posedge clk) begin
        if (imem.en) begin
            if (imem.we) begin
                imem_arr[imem.addr] <= imem.wdata;
            end
            imem.rdata <= imem_arr[imem.addr];
        end
    end

    // Data memory
    always_ff @(posedge clk) begin
        if (dmem.en) begin
            if (dmem.we) begin
                dmem_arr[dmem.addr] <= dmem.wdata;
            end
            dmem.rdata <= dmem_arr[dmem.addr];
        end
    end

endmodule

/* apb_host_port.sv */
`timescale 1ns/1ns

module apb_host_port import rv_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [host_aw-1:0] paddr,
    input  logic [xlen-1:0]    pwdata,
    input  logic               halt,
    output logic [xlen-1:0]    prdata,
    output logic               pslverr,
    output logic               run,
    output logic               start,
    mem_port_if.memory         core_fetch,
    mem_port_if.memory         core_data,
    mem_port_if.requester      mem_fetch,
    mem_port_if.requester      mem_data
);
    logic halted;
    logic setup, access;
    logic sel_imem, sel_dmem, sel_ctrl, err;
    logic host_rd, host_wr, ctrl_wr;

    assign setup  = psel && !penable;
    assign access = psel && penable;

    // Address map
    assign sel_imem = paddr[15:12] == host_imem_base[15:12];
    assign sel_dmem = paddr[15:12] == host_dmem_base[15:12];
    assign sel_ctrl = paddr == host_ctrl_addr;
    assign err      = !(sel_imem || sel_dmem || sel_ctrl) || ((sel_imem || sel_dmem) && run);

    // Reads go out in setup, writes land at end of access
    assign host_rd = setup && !pwrite && !err;
    assign host_wr = access && pwrite && !err;
    assign ctrl_wr = host_wr && sel_ctrl;

    assign mem_fetch.en    = run ? core_fetch.en : (host_rd || host_wr) && sel_imem;
    assign mem_fetch.we    = run ? core_fetch.we : host_wr;
    assign mem_fetch.addr  = run ? core_fetch.addr : paddr[mem_aw+1:2];
    assign mem_fetch.wdata = run ? core_fetch.wdata : pwdata;
    assign mem_data.en     = run ? core_data.en : (host_rd || host_wr) && sel_dmem;
    assign mem_data.we     = run ? core_data.we : host_wr;
    assign mem_data.addr   = run ? core_data.addr : paddr[mem_aw+1:2];
    assign mem_data.wdata  = run ? core_data.wdata : pwdata;
    assign core_fetch.rdata = mem_fetch.rdata;
    assign core_data.rdata  = mem_data.rdata;

    always_comb begin
        prdata = '0;
        if (access && !pwrite && !err) begin
            if (sel_imem) prdata = mem_fetch.rdata;
            else if (sel_dmem) prdata = mem_data.rdata;
            else prdata = {30'b0, halted, run};
        end
    end
    assign pslverr = access && err;

    // Control register, host write wins over a halt in the same cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            run    <= 1'b0;
            halted <= 1'b0;
            start  <= 1'b0;
        end else begin
            start <= 1'b0;
            if (halt) begin
                run    <= 1'b0;
                halted <= 1'b1;
            end
            if (ctrl_wr) begin
                run <= pwdata[0];
                if (pwdata[0]) begin
                    halted <= 1'b0;
                    start  <= 1'b1;
                end
            end
        end
    end

endmodule

/* rv_soc.sv */
`timescale 1ns/1ns

module rv_soc import rv_pkg::*; (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [host_aw-1:0] paddr,
    input  logic [xlen-1:0]    pwdata,
    output logic [xlen-1:0]    prdata,
    output logic               pslverr
);
    logic run;
    logic start;
    logic halt;

    // Core side and memory side of each port
    mem_port_if core_fetch ();
    mem_port_if core_data ();
    mem_port_if mem_fetch ();
    mem_port_if mem_data ();

    apb_host_port host_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .halt       (halt),
        .prdata     (prdata),
        .pslverr    (pslverr),
        .run        (run),
        .start      (start),
        .core_fetch (core_fetch),
        .core_data  (core_data),
        .mem_fetch  (mem_fetch),
        .mem_data   (mem_data)
    );

    rv_core core_i (
        .clk    (clk),
        .arst_n (arst_n),
        .run    (run),
        .start  (start),
        .halt   (halt),
        .fetch  (core_fetch),
        .data   (core_data)
    );

    rv_mem mem_i (
        .clk  (clk),
        .imem (mem_fetch),
        .dmem (mem_data)
    );

endmodule

/* tb_rv_soc.sv */
`timescale 1ns/1ns

module tb_rv_soc import rv_pkg::*; ();

    logic               clk;
    logic               arst_n;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic [host_aw-1:0] paddr;
    logic [xlen-1:0]    pwdata;
    logic [xlen-1:0]    prdata;
    logic               pslverr;

    rv_soc rv_soc_i (
        .clk     (clk),
        .arst_n  (arst_n),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pslverr (pslverr)
    );

    always #4 clk = ~clk;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "testbench stopped at the first error");
    endtask

    task automatic check_value(input logic [8*16-1:0] name, input logic [xlen-1:0] expected,
                               input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            stop_with_error($sformatf("Mismatch %0s: expected %h, actual %h",
                                      name, expected, actual));
        end
    endtask

    // Only the two 4 KB memories and the control word are decoded
    function automatic logic expect_error(input logic [host_aw-1:0] addr);
        logic in_mem;
        in_mem = addr >= host_imem_base && addr < host_dmem_base + 16'h1000;
        return !(in_mem || addr == host_ctrl_addr);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // APB transfers, entered and left 1 ns after a rising edge
    //////////////////////////////////////////////////////////////////////

    task automatic apb_write(input logic [host_aw-1:0] addr, input logic [xlen-1:0] data,
                             output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        err = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [host_aw-1:0] addr, output logic [xlen-1:0] data,
                            output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Start the core, probe the locked memory, then poll for halted
    task automatic run_program(input logic [8*16-1:0] name);
        logic            err;
        logic [xlen-1:0] rd;
        int              polls;
        apb_write(host_ctrl_addr, 32'h1, err);
        check_value(name, 32'd0, {31'b0, err});
        apb_read(host_dmem_base, rd, err);
        check_value(name, 32'd1, {31'b0, err});
        check_value(name, 32'd0, rd);
        polls = 0;
        rd    = '0;
        while (!rd[1]) begin
            if (polls == 2000) begin
                stop_with_error($sformatf("Timeout: core did not halt in %0s after 2000 polls",
                                          name));
            end
            apb_read(host_ctrl_addr, rd, err);
            polls++;
        end
    endtask

    initial begin
        integer          fd;
        integer          code;
        integer          ch;
        logic [7:0]      kind;
        logic [31:0]     addr;
        logic [31:0]     word;
        logic [xlen-1:0] rd;
        logic            err;
        logic [8*16-1:0] name;
        bit              done;

        clk     = 1'b0;
        arst_n  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;

        fd = $fopen("rv_soc_cases.txt", "r");
        if (fd == 0) begin
            stop_with_error("Cannot open the cases file rv_soc_cases.txt");
        end

        done = 1'b0;
        while (!done) begin
            code = $fscanf(fd, " %c", kind);
            if (code != 1) begin
                done = 1'b1;
            end else if (kind == "#") begin
                ch = $fgetc(fd);
                while (ch != 10 && ch != -1) begin
                    ch = $fgetc(fd);
                end
            end else if (kind == "L") begin
                code = $fscanf(fd, " %h %h", addr, word);
                if (code != 2) begin
                    stop_with_error("Malformed load record in the cases file");
                end
                apb_write(addr[host_aw-1:0], word, err);
                check_value("load", {31'b0, expect_error(addr[host_aw-1:0])}, {31'b0, err});
            end else if (kind == "R") begin
                code = $fscanf(fd, " %s", name);
                if (code != 1) begin
                    stop_with_error("Malformed run record in the cases file");
                end
                run_program(name);
            end else if (kind == "C") begin
                code = $fscanf(fd, " %s %h %h", name, addr, word);
                if (code != 3) begin
                    stop_with_error("Malformed check record in the cases file");
                end
                apb_read(addr[host_aw-1:0], rd, err);
                check_value(name, {31'b0, expect_error(addr[host_aw-1:0])}, {31'b0, err});
                check_value(name, word, rd);
            end else begin
                stop_with_error("Unknown record kind in the cases file");
            end
        end
        $fclose(fd);

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* rv_soc_cases.txt */
# L <host addr> <word>              APB write, pslverr expected only for unmapped addresses
# R <test name>                     start the core, wait for halted
# C <test name> <host addr> <word>  APB read, compare prdata with word
# Host access and the unmapped address
C reset_ctrl 2000 00000000
L 1000 0000CAFE
L 3000 DEADBEEF
C host_rw 1000 0000CAFE
C host_unmapped 3000 00000000
# ALU chain, forwarding and load-use
L 0000 00500093
L 0004 00708113
L 0008 002081B3
L 000C 40118233
L 0010 003242B3
L 0014 00329313
L 0018 FF000393
L 001C 4023D413
L 0020 01C3D493
L 0024 0013A533
L 0028 0013B5B3
L 002C 12345637
L 0030 00001697
L 0034 10D02023
L 0038 10C02223
L 003C 10402423
L 0040 10502623
L 0044 10602823
L 0048 10802A23
L 004C 10902C23
L 0050 10A02E23
L 0054 20002703
L 0058 001707B3
L 005C 12F02023
L 0060 12B02223
L 0064 00000073
L 1200 12340000
R alu_prog
C halt_alu 2000 00000002
C auipc 1100 00001030
C lui 1104 12345000
C sub 1108 0000000C
C xor 110C 0000001D
C slli 1110 000000E8
C srai 1114 FFFFFFFC
C srli 1118 0000000F
C slt 111C 00000001
C load_use 1120 12340005
C sltu 1124 00000000
# Loop, branches, JAL and JALR with wrong-path stores
L 0000 FFF00093
L 0004 02800113
L 0008 FFF10113
L 000C FE011EE3
L 0010 0020E463
L 0014 00010663
L 0018 14102023
L 001C 14102223
L 0020 00C001EF
L 0024 14102423
L 0028 14102423
L 002C 03C00267
L 0030 14102623
L 0034 14102623
L 0038 14102623
L 003C 14302823
L 0040 14402A23
L 0044 00000073
L 1140 A5A50140
L 1144 A5A50144
L 1148 A5A50148
L 114C A5A5014C
R branch_prog
C halt_branch 2000 00000002
C beq_marker0 1140 A5A50140
C beq_marker1 1144 A5A50144
C jal_marker 1148 A5A50148
C jalr_marker 114C A5A5014C
C jal_link 1150 00000024
C jalr_link 1154 00000030

/* sim.f */
rv_pkg.sv
mem_port_if.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_core.sv
rv_mem.sv
apb_host_port.sv
rv_soc.sv
tb_rv_soc.sv

/* Bender.yml */
package:
  name: rv_soc

sources:
  - rv_pkg.sv
  - mem_port_if.sv
  - rv_regfile.sv
  - rv_decode.sv
  - rv_execute.sv
  - rv_core.sv
  - rv_mem.sv
  - apb_host_port.sv
  - rv_soc.sv
  - target: simulation
    files:
      - tb_rv_soc.sv
